//--- include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Accumulator and data path width
`define CPU_DATA_WIDTH   8

// Memory address width, also the width of the address field of a word
`define CPU_ADDR_WIDTH   4

`define CPU_MEM_DEPTH    16 // Number of words in the unified memory

`define CPU_OPCODE_WIDTH 6 // Opcode field of a memory word

`endif

//--- src/cpuPkg.sv
`default_nettype none
`include "cpu_config.svh"

package cpuPkg;

    // Phase of the timing generator
    typedef enum logic {
        ADDRESS     = 1'b0,
        INSTRUCTION = 1'b1
    } modeT;

    typedef enum logic [2:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5,
        T6 = 3'd6
    } timeStateT;

    // Values not listed here execute as NOP
    typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
        NOP = 0,
        LDA = 1,
        ADD = 2,
        SUB = 3,
        AND = 4,
        STA = 5,
        OUT = 6,
        JMP = 7,
        JZ  = 8,
        HLT = 9
    } opcodeT;

    typedef logic [`CPU_DATA_WIDTH-1:0] dataT;

    // Data words sit in the low bits of a memory word
    typedef struct packed {
        logic [`CPU_OPCODE_WIDTH-1:0] opcode;
        logic [`CPU_ADDR_WIDTH-1:0]   address;
    } instrWordT;

    typedef struct packed {
        logic   addrSel;     // 0 selects the PC, 1 the current address
        logic   pcInc;
        logic   pcLoad;
        logic   operandLoad;
        logic   accLoad;
        opcodeT aluOp;
        logic   memWrite;
        logic   outLoad;
    } ctrlT;

endpackage

`default_nettype wire

//--- src/timingGenerator.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module timingGenerator (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       noAddressing,
    input  logic                       getInstruction,
    input  logic                       endAddressing,
    input  logic                       enableFFs,
    input  cpuPkg::opcodeT             decodedInstruction,
    input  logic [`CPU_ADDR_WIDTH-1:0] decodedAddress,
    output cpuPkg::opcodeT             currentInstruction,
    output logic [`CPU_ADDR_WIDTH-1:0] currentAddress,
    output cpuPkg::timeStateT          timeState,
    output cpuPkg::modeT               mode
);
    import cpuPkg::*;

    modeT      nextMode;
    timeStateT nextTime;

    always_comb begin : sequenceNext
        nextMode = mode; // Stay in the phase and step the time state by default
        case (timeState)
            T0:      nextTime = T1;
            T1:      nextTime = T2;
            T2:      nextTime = T3;
            T3:      nextTime = T4;
            T4:      nextTime = T5;
            T5:      nextTime = T6;
            default: nextTime = T0;
        endcase

        if (endAddressing) begin // Operand is in and execute follows
            nextMode = INSTRUCTION;
            nextTime = T0;
        end else if (getInstruction) begin // Fetch is done and the address phase starts
            nextMode = ADDRESS;
            nextTime = T0;
        end else if (mode == ADDRESS && noAddressing) begin
            // Instructions without an operand skip straight to execute
            nextMode = INSTRUCTION;
            nextTime = T0;
        end

        if (!enableFFs) begin // Hold the sequence while paused or halted
            nextMode = mode;
            nextTime = timeState;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin : sequenceRegs
        if (!nrst) begin
            mode      <= ADDRESS; // NOP is latched so the first pass skips to execute
            timeState <= T0;
        end else begin
            mode      <= nextMode;
            timeState <= nextTime;
        end
    end

    // The decoder runs all the time but its result is only taken at the end of fetch
    always_ff @(posedge clk or negedge nrst) begin : instrLatch
        if (!nrst) begin
            currentInstruction <= NOP;
            currentAddress     <= '0;
        end else if (enableFFs && getInstruction) begin
            currentInstruction <= decodedInstruction;
            currentAddress     <= decodedAddress;
        end
    end

    // Fetch ends at T2 and the address phase at T1, so the later states stay unused
    timeStateLegal: assert property (@(posedge clk) disable iff (!nrst)
        (mode == INSTRUCTION) ? (timeState inside {T0, T1, T2})
                              : (timeState inside {T0, T1}));

endmodule

`default_nettype wire

//--- src/sequenceController.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module sequenceController (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       run,
    input  cpuPkg::instrWordT          memWord,
    input  cpuPkg::opcodeT             currentInstruction,
    input  cpuPkg::timeStateT          timeState,
    input  cpuPkg::modeT               mode,
    input  logic                       zero,
    output cpuPkg::opcodeT             decodedInstruction,
    output logic [`CPU_ADDR_WIDTH-1:0] decodedAddress,
    output logic                       noAddressing,
    output logic                       getInstruction,
    output logic                       endAddressing,
    output logic                       enableFFs,
    output cpuPkg::ctrlT               ctrl,
    output logic                       halted
);
    import cpuPkg::*;

    logic haltSet;

    // Unknown opcodes fall back to NOP
    always_comb begin : decode
        case (memWord.opcode)
            NOP, LDA, ADD, SUB, AND, STA, OUT, JMP, JZ, HLT:
                decodedInstruction = opcodeT'(memWord.opcode);
            default:
                decodedInstruction = NOP;
        endcase
        decodedAddress = memWord.address;
    end

    // Only the operand instructions need the address phase
    assign noAddressing = !(currentInstruction inside {LDA, ADD, SUB, AND});

    assign enableFFs = run && !halted;

    always_comb begin : strobes
        ctrl           = '0;
        ctrl.addrSel   = 1'b1; // Current address unless the PC is being fetched
        ctrl.aluOp     = currentInstruction;
        getInstruction = 1'b0;
        endAddressing  = 1'b0;
        haltSet        = 1'b0;

        if (mode == INSTRUCTION) begin
            case (timeState)
                T0: begin
                    case (currentInstruction)
                        LDA, ADD, SUB, AND: ctrl.accLoad = 1'b1;
                        STA:                ctrl.memWrite = 1'b1;
                        OUT:                ctrl.outLoad = 1'b1;
                        JMP:                ctrl.pcLoad = 1'b1;
                        JZ:                 ctrl.pcLoad = zero;
                        HLT:                haltSet = 1'b1;
                        default:            ;
                    endcase
                end
                T1: begin
                    ctrl.addrSel = 1'b0; // Present the PC to memory
                end
                T2: begin
                    // Word at the PC is on the bus now
                    ctrl.addrSel   = 1'b0;
                    ctrl.pcInc     = 1'b1;
                    getInstruction = 1'b1;
                end
                default: ;
            endcase
        end else if (timeState == T1) begin
            ctrl.operandLoad = 1'b1; // Data word read in ADDRESS T0 is valid
            endAddressing    = 1'b1;
        end

        // The address select stays live so a paused machine keeps reading the same word
        if (!enableFFs) begin
            ctrl.pcInc       = 1'b0;
            ctrl.pcLoad      = 1'b0;
            ctrl.operandLoad = 1'b0;
            ctrl.accLoad     = 1'b0;
            ctrl.memWrite    = 1'b0;
            ctrl.outLoad     = 1'b0;
            getInstruction   = 1'b0;
            endAddressing    = 1'b0;
            haltSet          = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin : haltReg
        if (!nrst)
            halted <= 1'b0;
        else if (haltSet)
            halted <= 1'b1; // Only a reset leaves the halted state
    end

    phaseEndsExclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(getInstruction && endAddressing));

    quietWhenHalted: assert property (@(posedge clk) disable iff (!nrst)
        halted |-> !(ctrl.pcInc || ctrl.pcLoad || ctrl.operandLoad || ctrl.accLoad ||
                     ctrl.memWrite || ctrl.outLoad || getInstruction || endAddressing));

endmodule

`default_nettype wire

//--- src/dataPath.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module dataPath (
    input  logic                       clk,
    input  logic                       nrst,
    input  cpuPkg::ctrlT               ctrl,
    input  logic [`CPU_ADDR_WIDTH-1:0] currentAddress,
    input  cpuPkg::instrWordT          memWord,
    output logic [`CPU_ADDR_WIDTH-1:0] memAddr,
    output logic                       storeWrite,
    output cpuPkg::dataT               storeData,
    output logic                       zero,
    output cpuPkg::dataT               acc,
    output cpuPkg::dataT               outData,
    output logic                       outValid
);
    import cpuPkg::*;

    logic [`CPU_ADDR_WIDTH-1:0] pc;
    dataT                       operand;
    dataT                       aluResult;

    // One address bus serves fetch, operand read and store
    assign memAddr = ctrl.addrSel ? currentAddress : pc;

    assign storeWrite = ctrl.memWrite;
    assign storeData  = acc;

    assign zero = (acc == '0);

    always_ff @(posedge clk or negedge nrst) begin : pcReg
        if (!nrst)
            pc <= '0;
        else if (ctrl.pcLoad)
            pc <= currentAddress; // Jump target comes from the latched address
        else if (ctrl.pcInc)
            pc <= pc + 1'b1; // Wraps at the top of memory
    end

    // Data words live in the low bits of a memory word
    always_ff @(posedge clk) begin : operandReg
        if (ctrl.operandLoad)
            operand <= memWord[`CPU_DATA_WIDTH-1:0];
    end

    always_comb begin : alu
        case (ctrl.aluOp)
            LDA:     aluResult = operand;
            ADD:     aluResult = acc + operand; // Modulo 256, no carry kept
            SUB:     aluResult = acc - operand;
            AND:     aluResult = acc & operand;
            default: aluResult = acc;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin : accReg
        if (!nrst)
            acc <= '0;
        else if (ctrl.accLoad)
            acc <= aluResult;
    end

    // Output port holds its value while the valid flag lasts one cycle
    always_ff @(posedge clk or negedge nrst) begin : outReg
        if (!nrst) begin
            outData  <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= ctrl.outLoad;
            if (ctrl.outLoad)
                outData <= acc;
        end
    end

    // Two OUT instructions are always a full instruction cycle apart
    outPulseSingle: assert property (@(posedge clk) disable iff (!nrst)
        outValid |=> !outValid);

endmodule

`default_nettype wire

//--- src/unifiedMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module unifiedMemory #(
    parameter int depth = `CPU_MEM_DEPTH
) (
    input  logic                       clk,
    input  logic                       progWrite,
    input  logic [`CPU_ADDR_WIDTH-1:0] progAddr,
    input  cpuPkg::instrWordT          progWord,
    input  logic                       storeWrite,
    input  logic [`CPU_ADDR_WIDTH-1:0] storeAddr,
    input  cpuPkg::dataT               storeData,
    input  logic [`CPU_ADDR_WIDTH-1:0] readAddr,
    output cpuPkg::instrWordT          readWord
);
    import cpuPkg::*;

    instrWordT                     mem [depth];
    logic [$bits(instrWordT)-1:0]  storeBits;

    // Stored data lands in the low bits with a zero opcode field
    assign storeBits = {{($bits(instrWordT) - `CPU_DATA_WIDTH){1'b0}}, storeData};

    always_ff @(posedge clk) begin : writePort
        if (progWrite)
            mem[progAddr] <= progWord; // The loader wins over a store
        else if (storeWrite)
            mem[storeAddr] <= storeBits;
    end

    always_ff @(posedge clk) begin : readPort
        readWord <= mem[readAddr]; // Word is valid one clock after the address
    end

    // Loading only happens with the core stopped
    writeStrobesExclusive: assert property (@(posedge clk)
        !(progWrite && storeWrite));

endmodule

`default_nettype wire

//--- src/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpuCore (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       run,
    input  logic                       progWrite,
    input  logic [`CPU_ADDR_WIDTH-1:0] progAddr,
    input  cpuPkg::instrWordT          progWord,
    output logic                       outValid,
    output cpuPkg::dataT               outData,
    output logic                       halted,
    output cpuPkg::dataT               acc
);
    import cpuPkg::*;

    instrWordT                  memWord;
    opcodeT                     decodedInstruction;
    logic [`CPU_ADDR_WIDTH-1:0] decodedAddress;
    opcodeT                     currentInstruction;
    logic [`CPU_ADDR_WIDTH-1:0] currentAddress;
    timeStateT                  timeState;
    modeT                       mode;
    logic                       noAddressing;
    logic                       getInstruction;
    logic                       endAddressing;
    logic                       enableFFs;
    ctrlT                       ctrl;
    logic                       zero;
    logic [`CPU_ADDR_WIDTH-1:0] memAddr;
    logic                       storeWrite;
    dataT                       storeData;

    timingGenerator timingGenerator_i (
        .clk                (clk),
        .nrst               (nrst),
        .noAddressing       (noAddressing),
        .getInstruction     (getInstruction),
        .endAddressing      (endAddressing),
        .enableFFs          (enableFFs),
        .decodedInstruction (decodedInstruction),
        .decodedAddress     (decodedAddress),
        .currentInstruction (currentInstruction),
        .currentAddress     (currentAddress),
        .timeState          (timeState),
        .mode               (mode)
    );

    sequenceController sequenceController_i (
        .clk                (clk),
        .nrst               (nrst),
        .run                (run),
        .memWord            (memWord),
        .currentInstruction (currentInstruction),
        .timeState          (timeState),
        .mode               (mode),
        .zero               (zero),
        .decodedInstruction (decodedInstruction),
        .decodedAddress     (decodedAddress),
        .noAddressing       (noAddressing),
        .getInstruction     (getInstruction),
        .endAddressing      (endAddressing),
        .enableFFs          (enableFFs),
        .ctrl               (ctrl),
        .halted             (halted)
    );

    dataPath dataPath_i (
        .clk            (clk),
        .nrst           (nrst),
        .ctrl           (ctrl),
        .currentAddress (currentAddress),
        .memWord        (memWord),
        .memAddr        (memAddr),
        .storeWrite     (storeWrite),
        .storeData      (storeData),
        .zero           (zero),
        .acc            (acc),
        .outData        (outData),
        .outValid       (outValid)
    );

    // Reads and stores share the address bus from the data path
    unifiedMemory #(
        .depth (`CPU_MEM_DEPTH)
    ) unifiedMemory_i (
        .clk        (clk),
        .progWrite  (progWrite),
        .progAddr   (progAddr),
        .progWord   (progWord),
        .storeWrite (storeWrite),
        .storeAddr  (memAddr),
        .storeData  (storeData),
        .readAddr   (memAddr),
        .readWord   (memWord)
    );

endmodule

`default_nettype wire

//--- dv/cpuCorePrograms.svh
`ifndef CPU_CORE_PROGRAMS_SVH
`define CPU_CORE_PROGRAMS_SVH

// A word is {opcode, address} with NOP 0, LDA 1, ADD 2, SUB 3, AND 4, STA 5,
// OUT 6, JMP 7, JZ 8 and HLT 9, so 10'h01E reads as LDA from address E
typedef struct packed {
    instrWordT [0:`CPU_MEM_DEPTH-1] words;
    dataT [0:3]                     outs;     // Expected OUT values in order
    logic [2:0]                     numOuts;
    dataT                           finalAcc;
} programT;

localparam int numPrograms = 6;

// Each entry is words 0 to F, four expected outputs, output count, final accumulator
localparam programT [0:numPrograms-1] programTable = {
    // Arithmetic chain with C8, C8+64 wraps to 2C, 2C-3A wraps to F2, F2&3C is 30
    10'h01C, 10'h060, 10'h02D, 10'h060, 10'h03E, 10'h060, 10'h04F, 10'h060,
    10'h090, 10'h000, 10'h000, 10'h000, 10'h0C8, 10'h064, 10'h03A, 10'h03C,
    8'hC8, 8'h2C, 8'hF2, 8'h30, 3'd4, 8'h30,
    // 5A+B3 is 0D, stored to C over 3FF, then read back after reloading 5A
    10'h01E, 10'h02F, 10'h05C, 10'h01E, 10'h060, 10'h01C, 10'h060, 10'h090,
    10'h000, 10'h000, 10'h000, 10'h000, 10'h3FF, 10'h000, 10'h05A, 10'h0B3,
    8'h5A, 8'h0D, 8'h00, 8'h00, 3'd2, 8'h0D,
    // Countdown from 3 with JZ out of the loop and JMP back to the OUT
    10'h01D, 10'h060, 10'h03E, 10'h085, 10'h071, 10'h090, 10'h000, 10'h000,
    10'h000, 10'h000, 10'h000, 10'h000, 10'h000, 10'h003, 10'h001, 10'h000,
    8'h03, 8'h02, 8'h01, 8'h00, 3'd3, 8'h00,
    // Undefined opcodes 3F and 2A sit between the real instructions
    10'h01E, 10'h3F0, 10'h060, 10'h3F5, 10'h02F, 10'h2A7, 10'h060, 10'h090,
    10'h000, 10'h000, 10'h000, 10'h000, 10'h000, 10'h000, 10'h042, 10'h011,
    8'h42, 8'h53, 8'h00, 8'h00, 3'd2, 8'h53,
    // JZ not taken on 80, then 80+80 wraps to zero and JZ skips the ADD and OUT
    10'h01E, 10'h088, 10'h060, 10'h02E, 10'h087, 10'h02E, 10'h060, 10'h060,
    10'h090, 10'h000, 10'h000, 10'h000, 10'h000, 10'h000, 10'h080, 10'h000,
    8'h80, 8'h00, 8'h00, 8'h00, 3'd2, 8'h00,
    // CF&3C is 0C, stored twice, then 3C+0C+0C gives 54
    10'h01F, 10'h04E, 10'h05D, 10'h05C, 10'h01E, 10'h02D, 10'h02C, 10'h060,
    10'h090, 10'h000, 10'h000, 10'h000, 10'h3FF, 10'h3FF, 10'h03C, 10'h0CF,
    8'h54, 8'h00, 8'h00, 8'h00, 3'd1, 8'h54
};

`endif

//--- dv/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpuCoreTb;
    import cpuPkg::*;

    `include "cpuCorePrograms.svh"

    localparam int clockPeriod   = 10;
    localparam int cyclesPerTest = 400;
    localparam int quietCycles   = 20; // Cycles watched after the halt

    logic                       clk = 1'b0;
    logic                       nrst;
    logic                       run;
    logic                       progWrite;
    logic [`CPU_ADDR_WIDTH-1:0] progAddr;
    instrWordT                  progWord;
    logic                       outValid;
    dataT                       outData;
    logic                       halted;
    dataT                       acc;

    logic [31:0] lfsrState = 32'h1567690c;
    dataT        collected [$];
    int          checkCount = 0;
    int          errorCount = 0;

    cpuCore cpuCore_i (
        .clk       (clk),
        .nrst      (nrst),
        .run       (run),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progWord  (progWord),
        .outValid  (outValid),
        .outData   (outData),
        .halted    (halted),
        .acc       (acc)
    );

    always #(clockPeriod / 2) clk = ~clk;

    // Taps 32, 22, 2 and 1
    function automatic logic randomBit();
        logic feedback;
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [7:0] randomBits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
            value = {value[6:0], randomBit()};
        return value;
    endfunction

    task automatic compareData(input string name, input dataT actual, input dataT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic compareCount(input string name, input int actual, input int expected);
        checkCount++;
        if (actual != expected) begin
            errorCount++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic compareFlag(input string name, input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        nrst      <= 1'b0;
        run       <= 1'b0;
        progWrite <= 1'b0;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        compareFlag("halted", halted, 1'b0);
        compareFlag("outValid", outValid, 1'b0);
        compareData("acc", acc, 8'h00);
    endtask

    task automatic loadProgram(input programT prog);
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            @(posedge clk);
            progWrite <= 1'b1;
            progAddr  <= i[`CPU_ADDR_WIDTH-1:0];
            progWord  <= prog.words[i];
        end
        @(posedge clk);
        progWrite <= 1'b0;
    endtask

    // A quarter of the cycles start a pause of one to eight cycles
    task automatic runUntilHalt();
        int pauseLeft;
        pauseLeft = 0;
        collected.delete();
        while (!halted) begin
            @(posedge clk);
            if (pauseLeft > 0) begin
                run <= 1'b0;
                pauseLeft--;
            end else if (randomBits(2) == 2'b00) begin
                run <= 1'b0;
                pauseLeft = randomBits(3);
            end else begin
                run <= 1'b1;
            end
            @(negedge clk);
            if (outValid)
                collected.push_back(outData);
        end
    endtask

    task automatic checkResults(input programT prog);
        compareCount("output count", collected.size(), prog.numOuts);
        for (int i = 0; i < collected.size() && i < prog.numOuts; i++)
            compareData($sformatf("outData[%0d]", i), collected[i], prog.outs[i]);
        compareData("acc", acc, prog.finalAcc);
    endtask

    // Toggling run must not wake a halted machine
    task automatic checkQuietAfterHalt(input dataT expectedAcc);
        repeat (quietCycles) begin
            @(posedge clk);
            run <= randomBit();
            @(negedge clk);
            compareFlag("outValid", outValid, 1'b0);
            compareFlag("halted", halted, 1'b1);
            compareData("acc", acc, expectedAcc);
        end
        @(posedge clk);
        run <= 1'b0;
    endtask

    initial begin : mainSequence
        int errorsBefore;
        nrst      = 1'b0;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progWord  = '0;
        for (int t = 0; t < numPrograms; t++) begin
            errorsBefore = errorCount;
            resetDut();
            loadProgram(programTable[t]);
            runUntilHalt();
            checkResults(programTable[t]);
            checkQuietAfterHalt(programTable[t].finalAcc);
            $display("test %0d: %0d outputs, %0d errors", t, collected.size(),
                     errorCount - errorsBefore);
        end
        $display("%0d tests, %0d checks, %0d errors", numPrograms, checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin : watchdog
        #(numPrograms * cyclesPerTest * clockPeriod);
        $display("Timeout: the tests did not finish within %0d cycles",
                 numPrograms * cyclesPerTest);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpuCore.f
+incdir+include
+incdir+dv
src/cpuPkg.sv
src/timingGenerator.sv
src/sequenceController.sv
src/dataPath.sv
src/unifiedMemory.sv
src/cpuCore.sv
dv/cpuCoreTb.sv
